//--- rtl/memory_game_defines.svh
// Memory game widths and register map

`ifndef MEMORY_GAME_DEFINES_SVH
`define MEMORY_GAME_DEFINES_SVH

// Buttons and pattern
`define MG_BUTTONS          4
`define MG_PATTERN_LEN      16

// APB bus widths
`define MG_APB_ADDR_W       4
`define MG_APB_DATA_W       32

// Timeout length and its value after reset
`define MG_TIMEOUT_W        16
`define MG_TIMEOUT_DEFAULT  4000

// Register byte offsets
`define MG_REG_CTRL         4'h0
`define MG_REG_CONFIG       4'h4
`define MG_REG_TIMEOUT      4'h8
`define MG_REG_STATUS       4'hC

`endif

//--- rtl/memory_game_pkg.sv
// Memory game shared types

`include "memory_game_defines.svh"

package memory_game_pkg;

    // One bit per button, one-hot when valid
    typedef logic [`MG_BUTTONS-1:0] button_t;

    // Index of a pattern step or a round
    typedef logic [$clog2(`MG_PATTERN_LEN)-1:0] position_t;

    // Controller states
    typedef enum logic [3:0] {
        state_idle,
        state_prepare,
        state_wait_play,
        state_register_play,
        state_compare_play,
        state_next_play,
        state_round_end,
        state_next_round,
        state_end_won,
        state_end_lost,
        state_end_timeout
    } game_state_t;

    // Layout matches the STATUS register, done in bit 0
    typedef struct packed {
        position_t round;
        logic      timed_out;
        logic      lost;
        logic      won;
        logic      done;
    } game_status_t;

endpackage

//--- rtl/game_config_regs.sv
// Memory game APB register block

`include "memory_game_defines.svh"

module game_config_regs (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [`MG_APB_ADDR_W-1:0]       paddr,
    input  logic [`MG_APB_DATA_W-1:0]       pwdata,
    output logic [`MG_APB_DATA_W-1:0]       prdata,
    output logic                            pready,
    output logic                            pslverr,
    input  memory_game_pkg::game_status_t   status,
    output logic                            start,
    output logic                            hard,
    output logic [`MG_TIMEOUT_W-1:0]        timeout_len
);

    logic access;
    logic mapped;

    // Access phase of any transfer
    assign access = psel & penable;

    // No wait states
    assign pready = 1'b1;

    // --------------------------------------------------
    // Address decode and read path
    // --------------------------------------------------
    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            // Start is write-only
            `MG_REG_CTRL:    prdata = '0;
            `MG_REG_CONFIG:  prdata = `MG_APB_DATA_W'(hard);
            `MG_REG_TIMEOUT: prdata = `MG_APB_DATA_W'(timeout_len);
            `MG_REG_STATUS:  prdata = `MG_APB_DATA_W'(status);
            default:         mapped = 1'b0;
        endcase
    end

    // Error only on unmapped offsets
    assign pslverr = access & ~mapped;

    // --------------------------------------------------
    // Write path
    // --------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            start       <= 1'b0;
            hard        <= 1'b0;
            timeout_len <= `MG_TIMEOUT_W'(`MG_TIMEOUT_DEFAULT);
        end else begin
            // Start lasts one cycle after the write edge
            start <= access & pwrite & (paddr == `MG_REG_CTRL) & pwdata[0];
            if (access && pwrite) begin
                case (paddr)
                    `MG_REG_CONFIG:  hard <= pwdata[0];
                    `MG_REG_TIMEOUT: timeout_len <= pwdata[`MG_TIMEOUT_W-1:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- rtl/play_capture.sv
// Button press capture

module play_capture (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        clear,
    input  memory_game_pkg::button_t    buttons,
    output logic                        play_valid,
    output memory_game_pkg::button_t    play_value
);

    memory_game_pkg::button_t sample_q;
    logic any_q0;
    logic any_q1;
    logic rise;

    // Raw sample of the buttons, kept in step with any_q0
    always_ff @(posedge clock) begin
        sample_q <= buttons;
    end

    // New press: some button down now, none the cycle before
    assign rise = any_q0 & ~any_q1;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            any_q0     <= 1'b0;
            any_q1     <= 1'b0;
            play_valid <= 1'b0;
            play_value <= '0;
        end else begin
            any_q0     <= |buttons;
            any_q1     <= any_q0;
            play_valid <= rise;
            // Held until the next press or a new game
            if (clear)
                play_value <= '0;
            else if (rise)
                play_value <= sample_q;
        end
    end

endmodule

//--- rtl/sequence_datapath.sv
// Pattern, counters and play checks

`include "memory_game_defines.svh"

module sequence_datapath (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            clear_game,
    input  logic                            count_position,
    input  logic                            clear_position,
    input  logic                            count_round,
    input  logic                            time_play,
    input  logic                            hard,
    input  logic [`MG_TIMEOUT_W-1:0]        timeout_len,
    input  memory_game_pkg::button_t        play_value,
    output logic                            match,
    output logic                            at_round_end,
    output logic                            last_round,
    output logic                            timeout,
    output memory_game_pkg::position_t      round
);

    memory_game_pkg::position_t position;
    memory_game_pkg::button_t   pattern;
    logic                       hard_q;
    logic [`MG_TIMEOUT_W-1:0]   timer;

    // --------------------------------------------------
    // Step and round counters
    // --------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            position <= '0;
            round    <= '0;
            hard_q   <= 1'b0;
        end else begin
            if (clear_game || clear_position)
                position <= '0;
            else if (count_position)
                position <= position + 1'b1;

            if (clear_game)
                round <= '0;
            else if (count_round)
                round <= round + 1'b1;

            // Difficulty fixed for the whole game
            if (clear_game)
                hard_q <= hard;
        end
    end

    // Easy games stop after half the pattern
    assign last_round   = (round == (hard_q ? 4'd15 : 4'd7));
    assign at_round_end = (position == round);

    // --------------------------------------------------
    // Pattern ROM, one cycle read latency
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        case (position)
            4'd0:  pattern <= 4'b0001;
            4'd1:  pattern <= 4'b0010;
            4'd2:  pattern <= 4'b0100;
            4'd3:  pattern <= 4'b1000;
            4'd4:  pattern <= 4'b0100;
            4'd5:  pattern <= 4'b0010;
            4'd6:  pattern <= 4'b0001;
            4'd7:  pattern <= 4'b0001;
            4'd8:  pattern <= 4'b0010;
            4'd9:  pattern <= 4'b0010;
            4'd10: pattern <= 4'b0100;
            4'd11: pattern <= 4'b0100;
            4'd12: pattern <= 4'b1000;
            4'd13: pattern <= 4'b1000;
            4'd14: pattern <= 4'b0001;
            default: pattern <= 4'b0100;
        endcase
    end

    assign match = (play_value == pattern);

    // --------------------------------------------------
    // Wait timer, restarts on each wait
    // --------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            timer <= '0;
        else if (!time_play)
            timer <= '0;
        else if (!timeout)
            timer <= timer + 1'b1;
    end

    assign timeout = time_play && (timer == timeout_len - `MG_TIMEOUT_W'(1));

endmodule

//--- rtl/game_controller.sv
// Memory game control FSM

module game_controller (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            start,
    input  logic                            play_valid,
    input  logic                            match,
    input  logic                            at_round_end,
    input  logic                            last_round,
    input  logic                            timeout,
    input  memory_game_pkg::position_t      round,
    output logic                            clear_game,
    output logic                            count_position,
    output logic                            clear_position,
    output logic                            count_round,
    output logic                            time_play,
    output memory_game_pkg::game_status_t   status,
    output logic                            done,
    output logic                            won,
    output logic                            lost
);

    memory_game_pkg::game_state_t state;
    memory_game_pkg::game_state_t state_next;
    logic timed_out;

    // State register
    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            state <= memory_game_pkg::state_idle;
        else
            state <= state_next;
    end

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            memory_game_pkg::state_idle:
                if (start)
                    state_next = memory_game_pkg::state_prepare;
            memory_game_pkg::state_prepare:
                state_next = memory_game_pkg::state_wait_play;
            memory_game_pkg::state_wait_play: begin
                // A press wins over a timeout in the same cycle
                if (play_valid)
                    state_next = memory_game_pkg::state_register_play;
                else if (timeout)
                    state_next = memory_game_pkg::state_end_timeout;
            end
            // Lets the ROM word settle before the compare
            memory_game_pkg::state_register_play:
                state_next = memory_game_pkg::state_compare_play;
            memory_game_pkg::state_compare_play: begin
                if (!match)
                    state_next = memory_game_pkg::state_end_lost;
                else if (at_round_end)
                    state_next = memory_game_pkg::state_round_end;
                else
                    state_next = memory_game_pkg::state_next_play;
            end
            memory_game_pkg::state_next_play:
                state_next = memory_game_pkg::state_wait_play;
            memory_game_pkg::state_round_end:
                state_next = last_round ? memory_game_pkg::state_end_won
                                        : memory_game_pkg::state_next_round;
            memory_game_pkg::state_next_round:
                state_next = memory_game_pkg::state_wait_play;
            // End states wait for a new game
            memory_game_pkg::state_end_won,
            memory_game_pkg::state_end_lost,
            memory_game_pkg::state_end_timeout:
                if (start)
                    state_next = memory_game_pkg::state_prepare;
            default:
                state_next = memory_game_pkg::state_idle;
        endcase
    end

    // --------------------------------------------------
    // Moore outputs
    // --------------------------------------------------
    assign clear_game     = (state == memory_game_pkg::state_idle) ||
                            (state == memory_game_pkg::state_prepare);
    assign clear_position = (state == memory_game_pkg::state_next_round);
    assign count_position = (state == memory_game_pkg::state_next_play);
    assign count_round    = (state == memory_game_pkg::state_next_round);
    assign time_play      = (state == memory_game_pkg::state_wait_play);

    assign won       = (state == memory_game_pkg::state_end_won);
    assign lost      = (state == memory_game_pkg::state_end_lost);
    assign timed_out = (state == memory_game_pkg::state_end_timeout);
    assign done      = won | lost | timed_out;

    // Round counter is frozen in the end states
    always_comb begin
        status.round     = round;
        status.timed_out = timed_out;
        status.lost      = lost;
        status.won       = won;
        status.done      = done;
    end

endmodule

//--- rtl/memory_game_top.sv
// Memory game top level

`include "memory_game_defines.svh"

module memory_game_top (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`MG_APB_ADDR_W-1:0]   paddr,
    input  logic [`MG_APB_DATA_W-1:0]   pwdata,
    output logic [`MG_APB_DATA_W-1:0]   prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  memory_game_pkg::button_t    buttons,
    output memory_game_pkg::button_t    leds,
    output logic                        done,
    output logic                        won,
    output logic                        lost
);

    memory_game_pkg::game_status_t status;
    memory_game_pkg::position_t    round;
    memory_game_pkg::button_t      play_value;
    logic [`MG_TIMEOUT_W-1:0]      timeout_len;
    logic start;
    logic hard;
    logic play_valid;
    logic match;
    logic at_round_end;
    logic last_round;
    logic timeout;
    logic clear_game;
    logic count_position;
    logic clear_position;
    logic count_round;
    logic time_play;

    // LEDs show the last registered press
    assign leds = play_value;

    // Register block
    game_config_regs game_config_regs_i (
        .clock       (clock),
        .reset       (reset),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .status      (status),
        .start       (start),
        .hard        (hard),
        .timeout_len (timeout_len)
    );

    // Press capture, cleared for each new game
    play_capture play_capture_i (
        .clock      (clock),
        .reset      (reset),
        .clear      (clear_game),
        .buttons    (buttons),
        .play_valid (play_valid),
        .play_value (play_value)
    );

    sequence_datapath sequence_datapath_i (
        .clock          (clock),
        .reset          (reset),
        .clear_game     (clear_game),
        .count_position (count_position),
        .clear_position (clear_position),
        .count_round    (count_round),
        .time_play      (time_play),
        .hard           (hard),
        .timeout_len    (timeout_len),
        .play_value     (play_value),
        .match          (match),
        .at_round_end   (at_round_end),
        .last_round     (last_round),
        .timeout        (timeout),
        .round          (round)
    );

    game_controller game_controller_i (
        .clock          (clock),
        .reset          (reset),
        .start          (start),
        .play_valid     (play_valid),
        .match          (match),
        .at_round_end   (at_round_end),
        .last_round     (last_round),
        .timeout        (timeout),
        .round          (round),
        .clear_game     (clear_game),
        .count_position (count_position),
        .clear_position (clear_position),
        .count_round    (count_round),
        .time_play      (time_play),
        .status         (status),
        .done           (done),
        .won            (won),
        .lost           (lost)
    );

endmodule

//--- verification/memory_game_checker.sv
// Memory game output assertions

module memory_game_checker (
    input logic                            clock,
    input logic                            reset,
    input logic                            start,
    input logic                            done,
    input logic                            won,
    input logic                            lost,
    input memory_game_pkg::game_status_t   status,
    input memory_game_pkg::button_t        play_value
);
    timeunit 1ns;
    timeprecision 100ps;

    // At most one outcome at a time
    outcome_exclusive: assert property (@(posedge clock) disable iff (reset)
        $onehot0({won, lost, status.timed_out}))
        else $error("more than one outcome flag is high");

    // Done follows the outcomes
    done_is_outcome: assert property (@(posedge clock) disable iff (reset)
        done == (won | lost | status.timed_out))
        else $error("done differs from the OR of the outcomes");

    // Captured press is a single button or none
    play_value_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(play_value))
        else $error("play value has more than one button set");

    // Outcome frozen until the next start
    status_held: assert property (@(posedge clock) disable iff (reset)
        done && !start |=> $stable(status))
        else $error("status changed after the game ended");

endmodule

//--- verification/memory_game_tb.sv
// Memory game directed testbench

`include "memory_game_defines.svh"

module memory_game_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam time drive_delay = 1ns;
    // One press with hold and release
    localparam int press_cycles = 9;
    // Hard win, easy win and the loss game
    localparam int total_presses = 136 + 36 + 5;
    localparam int watchdog_cycles = 2 * (total_presses * press_cycles + 400);

    logic                        clock;
    logic                        reset;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [`MG_APB_ADDR_W-1:0]   paddr;
    logic [`MG_APB_DATA_W-1:0]   pwdata;
    logic [`MG_APB_DATA_W-1:0]   prdata;
    logic                        pready;
    logic                        pslverr;
    memory_game_pkg::button_t    buttons;
    memory_game_pkg::button_t    leds;
    logic                        done;
    logic                        won;
    logic                        lost;
    logic [31:0]                 lcg_state = 32'd32281;

    // Reference copy of the stored pattern
    memory_game_pkg::button_t pattern_model [0:`MG_PATTERN_LEN-1] = '{
        4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0100, 4'b0010, 4'b0001, 4'b0001,
        4'b0010, 4'b0010, 4'b0100, 4'b0100, 4'b1000, 4'b1000, 4'b0001, 4'b0100
    };

    memory_game_top memory_game_top_i (
        .clock   (clock),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .buttons (buttons),
        .leds    (leds),
        .done    (done),
        .won     (won),
        .lost    (lost)
    );

    // Internal status, start and capture value into the checker
    bind memory_game_top memory_game_checker checker_i (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .done       (done),
        .won        (won),
        .lost       (lost),
        .status     (status),
        .play_value (play_value)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        stop_run("watchdog expired before the tests finished");
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    task automatic stop_run(input string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_status(input string what,
                                  input memory_game_pkg::game_status_t actual,
                                  input memory_game_pkg::game_status_t expected);
        if (actual !== expected)
            stop_run($sformatf("mismatch at %0t: %s is %h, expected %h",
                               $time, what, actual, expected));
    endtask

    task automatic compare_button(input string what,
                                  input memory_game_pkg::button_t actual,
                                  input memory_game_pkg::button_t expected);
        if (actual !== expected)
            stop_run($sformatf("mismatch at %0t: %s is %b, expected %b",
                               $time, what, actual, expected));
    endtask

    task automatic compare_word(input string what,
                                input logic [`MG_APB_DATA_W-1:0] actual,
                                input logic [`MG_APB_DATA_W-1:0] expected);
        if (actual !== expected)
            stop_run($sformatf("mismatch at %0t: %s is %h, expected %h",
                               $time, what, actual, expected));
    endtask

    task automatic compare_bit(input string what, input logic actual, input logic expected);
        if (actual !== expected)
            stop_run($sformatf("mismatch at %0t: %s is %b, expected %b",
                               $time, what, actual, expected));
    endtask

    // Done is the OR of the three outcomes
    function automatic memory_game_pkg::game_status_t make_status(
        input memory_game_pkg::position_t round,
        input logic exp_won,
        input logic exp_lost,
        input logic exp_timed_out);
        memory_game_pkg::game_status_t s;
        s.round     = round;
        s.timed_out = exp_timed_out;
        s.lost      = exp_lost;
        s.won       = exp_won;
        s.done      = exp_won | exp_lost | exp_timed_out;
        return s;
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Random one-hot button other than the correct one
    function automatic memory_game_pkg::button_t pick_wrong_button(
        input memory_game_pkg::button_t correct);
        logic [31:0] r;
        memory_game_pkg::button_t b;
        r = lcg_next();
        b = 4'b0001 << r[17:16];
        if (b == correct)
            b = {b[2:0], b[3]};
        return b;
    endfunction

    // --------------------------------------------------
    // APB and button drivers
    // --------------------------------------------------
    task automatic apb_write(input logic [`MG_APB_ADDR_W-1:0] addr,
                             input logic [`MG_APB_DATA_W-1:0] data);
        @(posedge clock);
        #drive_delay;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clock);
        #drive_delay;
        penable = 1'b1;
        // Write lands on this edge
        @(posedge clock);
        #drive_delay;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [`MG_APB_ADDR_W-1:0] addr,
                            output logic [`MG_APB_DATA_W-1:0] data,
                            output logic err);
        @(posedge clock);
        #drive_delay;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clock);
        #drive_delay;
        penable = 1'b1;
        // Mid access phase, read data settled
        @(negedge clock);
        data = prdata;
        err  = pslverr;
        compare_bit("pready in access phase", pready, 1'b1);
        @(posedge clock);
        #drive_delay;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic press_button(input memory_game_pkg::button_t value);
        @(posedge clock);
        #drive_delay;
        buttons = value;
        repeat (4) @(posedge clock);
        #drive_delay;
        buttons = '0;
        repeat (4) @(posedge clock);
    endtask

    task automatic wait_done(input int max_cycles);
        int count;
        count = 0;
        do begin
            @(posedge clock);
            #drive_delay;
            count++;
            if (count > max_cycles)
                stop_run($sformatf("done did not rise within %0d cycles", max_cycles));
        end while (!done);
    endtask

    // Steps 0 to r of the pattern
    task automatic play_round(input int r);
        for (int s = 0; s <= r; s++)
            press_button(pattern_model[s]);
    endtask

    task automatic play_game(input int last);
        for (int r = 0; r <= last; r++)
            play_round(r);
    endtask

    task automatic start_game(input logic hard_mode);
        apb_write(`MG_REG_CONFIG, `MG_APB_DATA_W'(hard_mode));
        apb_write(`MG_REG_CTRL, `MG_APB_DATA_W'(1));
    endtask

    task automatic check_outcome(input string name,
                                 input memory_game_pkg::position_t round,
                                 input logic exp_won,
                                 input logic exp_lost,
                                 input logic exp_timed_out);
        logic [`MG_APB_DATA_W-1:0] data;
        logic err;
        memory_game_pkg::game_status_t expected;
        expected = make_status(round, exp_won, exp_lost, exp_timed_out);
        apb_read(`MG_REG_STATUS, data, err);
        compare_status({name, " STATUS"}, memory_game_pkg::game_status_t'(data[7:0]), expected);
        compare_bit({name, " done"}, done, expected.done);
        compare_bit({name, " won"}, won, expected.won);
        compare_bit({name, " lost"}, lost, expected.lost);
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_register_defaults();
        logic [`MG_APB_DATA_W-1:0] data;
        logic err;
        apb_read(`MG_REG_STATUS, data, err);
        compare_bit("STATUS pslverr", err, 1'b0);
        compare_word("STATUS after reset", data, '0);
        apb_read(`MG_REG_TIMEOUT, data, err);
        compare_word("TIMEOUT after reset", data, `MG_APB_DATA_W'(`MG_TIMEOUT_DEFAULT));
        apb_read(4'h2, data, err);
        compare_bit("pslverr on unmapped offset", err, 1'b1);
        apb_write(`MG_REG_CONFIG, 32'd1);
        apb_read(`MG_REG_CONFIG, data, err);
        compare_word("CONFIG readback", data, 32'd1);
        apb_write(`MG_REG_CONFIG, 32'd0);
        apb_read(`MG_REG_CONFIG, data, err);
        compare_word("CONFIG readback", data, 32'd0);
        apb_write(`MG_REG_TIMEOUT, 32'h0000_1234);
        apb_read(`MG_REG_TIMEOUT, data, err);
        compare_word("TIMEOUT readback", data, 32'h0000_1234);
        // Back to the default for the game tests
        apb_write(`MG_REG_TIMEOUT, `MG_APB_DATA_W'(`MG_TIMEOUT_DEFAULT));
    endtask

    task automatic test_easy_win();
        start_game(1'b0);
        play_game(7);
        wait_done(100);
        check_outcome("easy win", 4'd7, 1'b1, 1'b0, 1'b0);
        compare_button("leds after easy win", leds, pattern_model[7]);
    endtask

    task automatic test_hard_win();
        start_game(1'b1);
        play_game(15);
        wait_done(100);
        check_outcome("hard win", 4'd15, 1'b1, 1'b0, 1'b0);
        compare_button("leds after hard win", leds, pattern_model[15]);
    endtask

    task automatic test_loss();
        memory_game_pkg::button_t wrong;
        start_game(1'b0);
        play_round(0);
        play_round(1);
        // Round 2, second step is wrong
        press_button(pattern_model[0]);
        wrong = pick_wrong_button(pattern_model[1]);
        press_button(wrong);
        wait_done(100);
        check_outcome("loss", 4'd2, 1'b0, 1'b1, 1'b0);
        compare_button("leds after loss", leds, wrong);
    endtask

    task automatic test_timeout();
        apb_write(`MG_REG_TIMEOUT, 32'd50);
        apb_write(`MG_REG_CTRL, 32'd1);
        wait_done(200);
        check_outcome("timeout", 4'd0, 1'b0, 1'b0, 1'b1);
        // New game clears the outcome
        apb_write(`MG_REG_CTRL, 32'd1);
        check_outcome("restart", 4'd0, 1'b0, 1'b0, 1'b0);
    endtask

    initial begin
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        buttons = '0;
        repeat (5) @(posedge clock);
        #drive_delay;
        reset = 1'b0;
        test_register_defaults();
        test_easy_win();
        test_hard_win();
        test_loss();
        test_timeout();
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- list.f
+incdir+rtl
rtl/memory_game_pkg.sv
rtl/game_config_regs.sv
rtl/play_capture.sv
rtl/sequence_datapath.sv
rtl/game_controller.sv
rtl/memory_game_top.sv
verification/memory_game_checker.sv
verification/memory_game_tb.sv

//--- Makefile
BIN = obj_dir/memory_game_sim
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module memory_game_tb \
		-f list.f -Mdir obj_dir -o memory_game_sim

run: compile
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
